//--- build.f
rtl/div_pkg.sv
rtl/signed_divider.sv
rtl/div_wb_regs.sv
rtl/div_wb_top.sv
testbench/div_wb_props.sv
testbench/tb_div_wb_top.sv

//--- Makefile
# Verilator build and run for the divider peripheral

VERILATOR ?= verilator
TOP       := tb_div_wb_top
FILELIST  := build.f
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := FAIL: see errors above

# sources come from the file list, so a changed file triggers a rebuild
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_div_wb_top.sv
// ----------------------------------------------------------------------
// drives the divider peripheral over wishbone classic; bus accesses are
// full words only, every bus wait and status poll gives up after a limit
// ----------------------------------------------------------------------
module tb_div_wb_top;
    timeunit 1ns;
    timeprecision 100ps;

    logic                                clk;
    logic                                reset;
    logic                                wb_cyc;
    logic                                wb_stb;
    logic                                wb_we;
    logic [div_pkg::addr_width-1:0]      wb_adr;
    logic [div_pkg::data_width-1:0]      wb_dat_w;
    logic [div_pkg::data_width-1:0]      wb_dat_r;
    logic                                wb_ack;

    int                                  seed;
    int                                  pass_count;
    int                                  fail_count;
    int                                  test_errors;

    // last division, handed to the compare process
    string                               res_name;
    logic signed [31:0]                  res_a;
    logic signed [31:0]                  res_b;
    logic signed [31:0]                  res_q;
    logic signed [31:0]                  res_r;
    event                                result_ev;

    div_wb_top u_div_wb_top (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // reference model and checking
    // ------------------------------------------------------------------
    // truncates toward zero, remainder follows the dividend's sign
    function automatic logic [63:0] ref_div(input logic signed [31:0] a,
                                            input logic signed [31:0] b);
        logic [31:0] a_mag;
        logic [31:0] b_mag;
        logic [31:0] q;
        logic [31:0] r;
        a_mag = a[31] ? -a : a;
        b_mag = b[31] ? -b : b;
        if (b == 0) begin
            // zero divisor: all ones magnitude, remainder is the dividend
            q = '1;
            r = a_mag;
        end else begin
            q = a_mag / b_mag;
            r = a_mag % b_mag;
        end
        if (a[31] ^ b[31]) q = -q;
        if (a[31]) r = -r;
        return {q, r};
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout: %s", what);
        fail_count++;
        test_errors++;
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    always @(result_ev) begin : compare
        logic [63:0] expected;
        expected = ref_div(res_a, res_b);
        check({res_name, " quotient"}, expected[63:32], res_q);
        check({res_name, " remainder"}, expected[31:0], res_r);
    end

    // ------------------------------------------------------------------
    // bus tasks
    // ------------------------------------------------------------------
    task automatic wb_access(input logic we, input logic [2:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < 20);
        rdata = wb_dat_r;
        if (!wb_ack) report_timeout($sformatf("no ack for access to address %0d", adr));
        // request drops on the edge that ends the ack
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'h0, data);
    endtask

    task automatic wait_done(output logic [31:0] status);
        int tries;
        tries  = 0;
        status = '0;
        while (!status[div_pkg::stat_done_bit] && tries < 100) begin
            wb_read(div_pkg::reg_ctrl, status);
            tries++;
        end
        if (!status[div_pkg::stat_done_bit]) report_timeout("done bit never set after start");
    endtask

    task automatic collect_result(input string name, input logic [31:0] a,
                                  input logic [31:0] b);
        logic [31:0] q;
        logic [31:0] r;
        wb_read(div_pkg::reg_quotient, q);
        wb_read(div_pkg::reg_remainder, r);
        res_name = name;
        res_a    = a;
        res_b    = b;
        res_q    = q;
        res_r    = r;
        -> result_ev;
        @(posedge clk);
    endtask

    task automatic run_div(input string name, input logic [31:0] a,
                           input logic [31:0] b, output logic [31:0] status);
        wb_write(div_pkg::reg_dividend, a);
        wb_write(div_pkg::reg_divisor, b);
        wb_write(div_pkg::reg_ctrl, 32'h1);
        wait_done(status);
        collect_result(name, a, b);
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        logic [31:0]        rd;
        logic [31:0]        status;
        logic signed [31:0] a;
        logic signed [31:0] b;
        seed        = 74;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        reset       = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        wb_read(div_pkg::reg_ctrl, rd);
        check("reset status", 32'h0, rd);
        wb_read(div_pkg::reg_dividend, rd);
        check("reset dividend", 32'h0, rd);
        wb_read(div_pkg::reg_divisor, rd);
        check("reset divisor", 32'h0, rd);
        wb_write(div_pkg::reg_dividend, 32'h1234_5678);
        wb_write(div_pkg::reg_divisor, 32'hfedc_ba98);
        wb_read(div_pkg::reg_dividend, rd);
        check("dividend readback", 32'h1234_5678, rd);
        wb_read(div_pkg::reg_divisor, rd);
        check("divisor readback", 32'hfedc_ba98, rd);
        end_test("reset_and_registers");

        run_div("pos_by_pos", 7, 3, status);
        run_div("neg_by_pos", -7, 3, status);
        run_div("pos_by_neg", 7, -3, status);
        run_div("neg_by_neg", -7, -3, status);
        end_test("sign_combinations");

        for (int i = 0; i < 200; i++) begin
            a = $random(seed);
            b = $random(seed);
            // narrower divisors give larger quotients
            if (i % 3 == 0) b = b >>> (i % 31);
            run_div("random", a, b, status);
        end
        for (int i = 0; i < 4; i++) begin
            a = $random(seed);
            b = i[0] ? -1 : 1;
            run_div("unit_divisor", a, b, status);
        end
        for (int i = 0; i < 4; i++) begin
            a = $random(seed) % 1000;
            b = i[0] ? -(1000 + i) : (1000 + i);
            run_div("small_dividend", a, b, status);
        end
        end_test("random_operands");

        run_div("pos_by_zero", 12345, 0, status);
        check("dz set", 32'h1, 32'(status[div_pkg::stat_dz_bit]));
        run_div("neg_by_zero", -12345, 0, status);
        check("dz set negative", 32'h1, 32'(status[div_pkg::stat_dz_bit]));
        run_div("after_zero", 100, 9, status);
        check("dz cleared", 32'h0, 32'(status[div_pkg::stat_dz_bit]));
        run_div("min_by_minus_one", 32'h8000_0000, -1, status);
        end_test("edge_cases");

        wb_write(div_pkg::reg_dividend, 100);
        wb_write(div_pkg::reg_divisor, 7);
        wb_write(div_pkg::reg_ctrl, 32'h1);
        wb_read(div_pkg::reg_ctrl, rd);
        check("busy after start", 32'h1, 32'(rd[div_pkg::stat_busy_bit]));
        wb_write(div_pkg::reg_dividend, 50);
        wb_write(div_pkg::reg_divisor, 5);
        // dropped, the core is still running
        wb_write(div_pkg::reg_ctrl, 32'h1);
        wait_done(status);
        collect_result("first_of_two_starts", 100, 7);
        wb_read(div_pkg::reg_dividend, rd);
        check("dividend written while busy", 32'd50, rd);
        wb_read(div_pkg::reg_divisor, rd);
        check("divisor written while busy", 32'd5, rd);
        wb_write(div_pkg::reg_ctrl, 32'h1);
        wait_done(status);
        collect_result("later_start", 50, 5);
        end_test("start_while_busy");

        for (int adr = 5; adr < 8; adr++) begin
            wb_write(adr[2:0], 32'hdead_beef);
            wb_read(adr[2:0], rd);
            check($sformatf("unmapped address %0d", adr), 32'h0, rd);
        end
        end_test("unmapped_addresses");

        fail_count += u_div_wb_top.u_props.assert_errors;
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- testbench/div_wb_props.sv
// ----------------------------------------------------------------------
// bus and core-launch rules, bound into the peripheral top level
// ----------------------------------------------------------------------
module div_wb_props (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic start,
    input logic busy,
    input logic done_pulse
);
    timeunit 1ns;
    timeprecision 100ps;

    int assert_errors = 0;

    ack_with_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            assert_errors++;
            $error("ack high without an active request");
        end

    // single pulse per request
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else begin
            assert_errors++;
            $error("ack high on two consecutive cycles");
        end

    // an accepted start puts the core into its run state on the same edge
    start_launches_core: assert property (@(posedge clk) disable iff (reset)
        start |=> busy)
        else begin
            assert_errors++;
            $error("start accepted but the core did not become busy");
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        done_pulse |=> !done_pulse)
        else begin
            assert_errors++;
            $error("done pulse longer than one cycle");
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (!wb_ack && !busy && !start))
        else begin
            assert_errors++;
            $error("ack, busy or start high right after reset");
        end

endmodule

bind div_wb_top div_wb_props u_props (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .start      (start),
    .busy       (busy),
    .done_pulse (done_pulse)
);

//--- rtl/div_wb_top.sv
// ---------------------------------------------------------------------
// divider peripheral, register block in front of the core
// ---------------------------------------------------------------------
module div_wb_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [div_pkg::addr_width-1:0]    wb_adr,
    input  logic [div_pkg::data_width-1:0]    wb_dat_w,
    output logic [div_pkg::data_width-1:0]    wb_dat_r,
    output logic                              wb_ack
);

    // link between register block and core
    logic                                     start;
    logic                                     busy;
    logic                                     done_pulse;
    logic signed [div_pkg::data_width-1:0]    dividend;
    logic signed [div_pkg::data_width-1:0]    divisor;
    logic signed [div_pkg::data_width-1:0]    quotient;
    logic signed [div_pkg::data_width-1:0]    remainder;

    div_wb_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .busy       (busy),
        .done_pulse (done_pulse),
        .quotient   (quotient),
        .remainder  (remainder),
        .start      (start),
        .dividend   (dividend),
        .divisor    (divisor)
    );

    signed_divider u_core (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .dividend   (dividend),
        .divisor    (divisor),
        .busy       (busy),
        .done_pulse (done_pulse),
        .quotient   (quotient),
        .remainder  (remainder)
    );

endmodule

//--- rtl/div_wb_regs.sv
// ---------------------------------------------------------------------
// wishbone classic slave, full-word accesses only, no bursts;
// a start write while the core is busy is dropped
// ---------------------------------------------------------------------
module div_wb_regs (
    input  logic                                     clk,
    input  logic                                     reset,
    // bus side
    input  logic                                     wb_cyc,
    input  logic                                     wb_stb,
    input  logic                                     wb_we,
    input  logic [div_pkg::addr_width-1:0]           wb_adr,
    input  logic [div_pkg::data_width-1:0]           wb_dat_w,
    output logic [div_pkg::data_width-1:0]           wb_dat_r,
    output logic                                     wb_ack,
    // core side
    input  logic                                     busy,
    input  logic                                     done_pulse,
    input  logic signed [div_pkg::data_width-1:0]    quotient,
    input  logic signed [div_pkg::data_width-1:0]    remainder,
    output logic                                     start,
    output logic signed [div_pkg::data_width-1:0]    dividend,
    output logic signed [div_pkg::data_width-1:0]    divisor
);

    div_pkg::reg_addr_e                reg_sel;
    logic                              access;
    logic                              wr_access;
    logic                              done_flag;
    logic                              dz_flag;
    logic [div_pkg::data_width-1:0]    status;
    logic [div_pkg::data_width-1:0]    rd_data;

    assign reg_sel = div_pkg::reg_addr_e'(wb_adr);

    // new request only while ack is low, so a held request acks every other cycle
    assign access    = wb_cyc && wb_stb && !wb_ack;
    assign wr_access = access && wb_we;

    // launch on the same edge that acks the ctrl write
    assign start = wr_access && (reg_sel == div_pkg::reg_ctrl) && wb_dat_w[0] && !busy;

    // ---------------------------------------------------------------
    // handshake and operand registers
    // ---------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dividend <= '0;
            divisor  <= '0;
        end else if (wr_access) begin
            case (reg_sel)
                div_pkg::reg_dividend: dividend <= signed'(wb_dat_w);
                div_pkg::reg_divisor:  divisor  <= signed'(wb_dat_w);
                default: ;
            endcase
        end
    end

    // done until the next accepted start, dz sampled at that start
    always_ff @(posedge clk) begin
        if (reset) begin
            done_flag <= 1'b0;
            dz_flag   <= 1'b0;
        end else if (start) begin
            done_flag <= 1'b0;
            dz_flag   <= (divisor == '0);
        end else if (done_pulse) begin
            done_flag <= 1'b1;
        end
    end

    // ---------------------------------------------------------------
    // read path
    // ---------------------------------------------------------------
    always_comb begin
        status                         = '0;
        status[div_pkg::stat_busy_bit] = busy;
        status[div_pkg::stat_done_bit] = done_flag;
        status[div_pkg::stat_dz_bit]   = dz_flag;
    end

    always_comb begin
        case (reg_sel)
            div_pkg::reg_dividend:  rd_data = dividend;
            div_pkg::reg_divisor:   rd_data = divisor;
            div_pkg::reg_ctrl:      rd_data = status;
            div_pkg::reg_quotient:  rd_data = quotient;
            div_pkg::reg_remainder: rd_data = remainder;
            // unmapped words read zero
            default:                rd_data = '0;
        endcase
    end

    // captured with the ack, valid while ack is high
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

endmodule

//--- rtl/signed_divider.sv
// ---------------------------------------------------------------------
// restoring divider, one clock per quotient bit; start must not arrive
// while busy. results hold until the next start, no output handshake
// ---------------------------------------------------------------------
module signed_divider (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     start,
    input  logic signed [div_pkg::data_width-1:0]    dividend,
    input  logic signed [div_pkg::data_width-1:0]    divisor,
    output logic                                     busy,
    output logic                                     done_pulse,
    output logic signed [div_pkg::data_width-1:0]    quotient,
    output logic signed [div_pkg::data_width-1:0]    remainder
);

    // two's complement negation when the flag is set
    function automatic logic [div_pkg::data_width-1:0] apply_sign(
        input logic [div_pkg::data_width-1:0] value,
        input logic                           negate
    );
        return negate ? ~value + 1'b1 : value;
    endfunction

    div_pkg::div_state_e               state;
    logic [div_pkg::iter_width-1:0]    iter_cnt;

    // unsigned working registers
    logic [div_pkg::data_width-1:0]    quo_mag;
    logic [div_pkg::data_width-1:0]    rem_mag;
    logic [div_pkg::data_width-1:0]    div_mag;
    logic                              quo_neg;
    logic                              rem_neg;

    logic [div_pkg::data_width-1:0]    rem_shift;
    logic [div_pkg::data_width-1:0]    quo_shift;
    logic [div_pkg::data_width:0]      trial;

    // ---------------------------------------------------------------
    // one restoring step
    // ---------------------------------------------------------------
    // partial remainder stays below the divisor, so the shift fits
    assign rem_shift = {rem_mag[div_pkg::data_width-2:0], quo_mag[div_pkg::data_width-1]};
    assign trial     = {1'b0, rem_shift} - {1'b0, div_mag};
    // no borrow means the subtraction fits, quotient bit is one
    assign quo_shift = {quo_mag[div_pkg::data_width-2:0], ~trial[div_pkg::data_width]};

    // ---------------------------------------------------------------
    // sequencing
    // ---------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= div_pkg::st_idle;
            iter_cnt <= '0;
        end else if (start) begin
            state    <= div_pkg::st_run;
            iter_cnt <= '0;
        end else begin
            case (state)
                div_pkg::st_run: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (iter_cnt == div_pkg::last_iter) begin
                        state <= div_pkg::st_done;
                    end
                end
                // done lasts a single cycle
                default: state <= div_pkg::st_idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (start) begin
            rem_mag <= '0;
            quo_mag <= apply_sign(dividend, dividend[div_pkg::data_width-1]);
            div_mag <= apply_sign(divisor, divisor[div_pkg::data_width-1]);
            quo_neg <= dividend[div_pkg::data_width-1] ^ divisor[div_pkg::data_width-1];
            rem_neg <= dividend[div_pkg::data_width-1];
        end else if (state == div_pkg::st_run) begin
            rem_mag <= trial[div_pkg::data_width] ? rem_shift
                                                  : trial[div_pkg::data_width-1:0];
            quo_mag <= quo_shift;
        end
    end

    assign busy       = (state == div_pkg::st_run);
    assign done_pulse = (state == div_pkg::st_done);

    // a zero divisor gives all ones and the dividend as remainder
    assign quotient  = signed'(apply_sign(quo_mag, quo_neg));
    assign remainder = signed'(apply_sign(rem_mag, rem_neg));

endmodule

//--- rtl/div_pkg.sv
// ---------------------------------------------------------------------
// one fixed data width; the register map is word addressed, 3 bits wide
// status bits sit in the low bits of a reg_ctrl read, the rest read zero
// ---------------------------------------------------------------------
package div_pkg;

    // widths
    localparam int data_width = 32;
    localparam int addr_width = 3;

    // one shift-subtract step per quotient bit
    localparam int div_iterations = data_width;
    localparam int iter_width = $clog2(div_iterations);
    localparam logic [iter_width-1:0] last_iter = iter_width'(div_iterations - 1);

    // ---------------------------------------------------------------
    // register map
    // ---------------------------------------------------------------
    typedef enum logic [addr_width-1:0] {
        reg_dividend  = 3'd0,
        reg_divisor   = 3'd1,
        reg_ctrl      = 3'd2,
        reg_quotient  = 3'd3,
        reg_remainder = 3'd4
    } reg_addr_e;

    // status bit positions in a reg_ctrl read
    localparam int stat_busy_bit = 0;
    localparam int stat_done_bit = 1;
    localparam int stat_dz_bit   = 2;

    // core sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_done
    } div_state_e;

endpackage
